//--- source/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// data and address bus width
`define BRIDGE_WIDTH 32

// number of APB slaves behind the bridge
`define BRIDGE_SLAVES 4

// config space runs from address 0 up to this one
`define CFG_ADDR_LAST 8

// window bases after reset
`define SLAVE_BASE_0 32'h8000_0000
`define SLAVE_BASE_1 32'h8400_0000
`define SLAVE_BASE_2 32'h8800_0000
`define SLAVE_BASE_3 32'h8C00_0000

// window size after reset, same for all slaves
`define SLAVE_OFFSET_RST 32'h0000_03FF

`endif

//--- source/ahb_pkg.sv
`default_nettype none
`include "bridge_params.svh"

package ahb_pkg;

	// bus address and data words
	typedef logic [`BRIDGE_WIDTH-1:0] addr_t;
	typedef logic [`BRIDGE_WIDTH-1:0] data_t;

	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// log2 of the transfer size in bytes
	typedef logic [2:0] hsize_t;

	typedef enum logic [1:0]
	{
		OKAY  = 2'b00,
		ERROR = 2'b10
	} hresp_e;

endpackage

`default_nettype wire

//--- source/regmap_pkg.sv
`default_nettype none
`include "bridge_params.svh"

package regmap_pkg;

	// one bit per APB slave
	typedef logic [`BRIDGE_SLAVES-1:0] slave_sel_t;

	// config address, 1..8 map to base/offset pairs
	typedef logic [3:0] cfg_index_t;

	// two-cycle error response
	typedef enum logic [1:0]
	{
		ERR_IDLE   = 2'b00,
		ERR_FIRST  = 2'b01,
		ERR_SECOND = 2'b10
	} err_state_e;

endpackage

`default_nettype wire

//--- source/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module cfg_regs (
	input  wire logic             Hclk,
	input  wire logic             Hresetn,
	input  wire ahb_pkg::htrans_e htrans,
	input  wire logic             hwrite,
	input  wire logic             hreadyin,
	input  wire ahb_pkg::addr_t   haddr,
	input  wire ahb_pkg::data_t   hwdata,
	input  wire ahb_pkg::hresp_e  hresp,
	output ahb_pkg::addr_t        base_0,
	output ahb_pkg::addr_t        base_1,
	output ahb_pkg::addr_t        base_2,
	output ahb_pkg::addr_t        base_3,
	output ahb_pkg::addr_t        offset_0,
	output ahb_pkg::addr_t        offset_1,
	output ahb_pkg::addr_t        offset_2,
	output ahb_pkg::addr_t        offset_3,
	output ahb_pkg::data_t        config_reg_data
);

	logic                   active;
	logic                   in_cfg;
	logic                   wr_pend;
	regmap_pkg::cfg_index_t wr_index;
	regmap_pkg::cfg_index_t rd_index;
	ahb_pkg::data_t         rd_mux;

	assign active = hreadyin && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);
	assign in_cfg = (haddr <= `CFG_ADDR_LAST);
	assign rd_index = haddr[3:0];

	// write address held over into the data phase
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			wr_pend <= 1'b0;
		else
			wr_pend <= active && hwrite && in_cfg;
	end

	always_ff @(posedge Hclk)
	begin
		if (active && hwrite && in_cfg)
			wr_index <= haddr[3:0];
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			base_0   <= `SLAVE_BASE_0;
			base_1   <= `SLAVE_BASE_1;
			base_2   <= `SLAVE_BASE_2;
			base_3   <= `SLAVE_BASE_3;
			offset_0 <= `SLAVE_OFFSET_RST;
			offset_1 <= `SLAVE_OFFSET_RST;
			offset_2 <= `SLAVE_OFFSET_RST;
			offset_3 <= `SLAVE_OFFSET_RST;
		end
		else if (wr_pend && hresp == ahb_pkg::OKAY) // dropped if the data phase errors
		begin
			case (wr_index)
				4'd1: base_0   <= hwdata;
				4'd2: offset_0 <= hwdata;
				4'd3: base_1   <= hwdata;
				4'd4: offset_1 <= hwdata;
				4'd5: base_2   <= hwdata;
				4'd6: offset_2 <= hwdata;
				4'd7: base_3   <= hwdata;
				4'd8: offset_3 <= hwdata;
				default: ; // address 0 has no register
			endcase
		end
	end

	always_comb
	begin
		case (rd_index)
			4'd1: rd_mux = base_0;
			4'd2: rd_mux = offset_0;
			4'd3: rd_mux = base_1;
			4'd4: rd_mux = offset_1;
			4'd5: rd_mux = base_2;
			4'd6: rd_mux = offset_2;
			4'd7: rd_mux = base_3;
			4'd8: rd_mux = offset_3;
			default: rd_mux = '0;
		endcase
	end

	// holds until the next config read
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			config_reg_data <= '0;
		else if (active && !hwrite && in_cfg)
			config_reg_data <= rd_mux;
	end

endmodule

`default_nettype wire

//--- source/slave_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module slave_decoder (
	input  wire ahb_pkg::addr_t haddr,
	input  wire ahb_pkg::addr_t base_0,
	input  wire ahb_pkg::addr_t base_1,
	input  wire ahb_pkg::addr_t base_2,
	input  wire ahb_pkg::addr_t base_3,
	input  wire ahb_pkg::addr_t offset_0,
	input  wire ahb_pkg::addr_t offset_1,
	input  wire ahb_pkg::addr_t offset_2,
	input  wire ahb_pkg::addr_t offset_3,
	output regmap_pkg::slave_sel_t pselx_out
);

	ahb_pkg::addr_t base [`BRIDGE_SLAVES];
	ahb_pkg::addr_t limit [`BRIDGE_SLAVES];

	assign base[0] = base_0;
	assign base[1] = base_1;
	assign base[2] = base_2;
	assign base[3] = base_3;

	// upper bound is exclusive
	assign limit[0] = base_0 + offset_0;
	assign limit[1] = base_1 + offset_1;
	assign limit[2] = base_2 + offset_2;
	assign limit[3] = base_3 + offset_3;

	// overlapping windows can raise several selects
	always_comb
	begin
		for (int i = 0; i < `BRIDGE_SLAVES; i++)
		begin
			pselx_out[i] = (haddr >= base[i]) && (haddr < limit[i]);
		end
	end

endmodule

`default_nettype wire

//--- source/xfer_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module xfer_checker (
	input  wire logic             Hclk,
	input  wire logic             Hresetn,
	input  wire ahb_pkg::htrans_e htrans,
	input  wire ahb_pkg::hsize_t  hsize,
	input  wire logic             hwrite,
	input  wire logic             hreadyin,
	input  wire ahb_pkg::addr_t   haddr,
	output ahb_pkg::hresp_e       hresp,
	output logic                  err_first
);

	logic                   active;
	logic                   in_cfg;
	ahb_pkg::htrans_e       htrans_q;
	ahb_pkg::hsize_t        hsize_q;
	logic                   hwrite_q;
	ahb_pkg::addr_t         align_mask;
	logic                   misaligned;
	logic                   seq_after_idle;
	logic                   burst_change;
	logic                   oversize;
	logic                   fault;
	regmap_pkg::err_state_e state;
	regmap_pkg::err_state_e state_nxt;

	assign active = hreadyin && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);
	assign in_cfg = (haddr <= `CFG_ADDR_LAST);

	// previous cycle's control, for the burst checks
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			htrans_q <= ahb_pkg::IDLE;
			hsize_q  <= '0;
			hwrite_q <= 1'b0;
		end
		else
		begin
			htrans_q <= htrans;
			hsize_q  <= hsize;
			hwrite_q <= hwrite;
		end
	end

	// low address bits that must be zero for this size
	assign align_mask = ahb_pkg::addr_t'((32'd1 << hsize) - 32'd1);

	assign misaligned = !in_cfg && ((haddr & align_mask) != '0);
	assign seq_after_idle = (htrans == ahb_pkg::SEQ) && (htrans_q == ahb_pkg::IDLE);
	assign burst_change = (htrans == ahb_pkg::SEQ) && (htrans_q == ahb_pkg::NONSEQ)
		&& ((hsize != hsize_q) || (hwrite != hwrite_q));
	assign oversize = (32'd1 << hsize) > (`BRIDGE_WIDTH / 8); // bytes vs bus bytes

	assign fault = active && (misaligned || seq_after_idle || burst_change || oversize);

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			state <= regmap_pkg::ERR_IDLE;
		else
			state <= state_nxt;
	end

	// faults are only looked at from ERR_IDLE
	always_comb
	begin
		state_nxt = state;
		case (state)
			regmap_pkg::ERR_IDLE:
			begin
				if (fault)
					state_nxt = regmap_pkg::ERR_FIRST;
			end
			regmap_pkg::ERR_FIRST:
				state_nxt = regmap_pkg::ERR_SECOND;
			default:
				state_nxt = regmap_pkg::ERR_IDLE;
		endcase
	end

	assign hresp = (state == regmap_pkg::ERR_IDLE) ? ahb_pkg::OKAY : ahb_pkg::ERROR;
	assign err_first = (state == regmap_pkg::ERR_FIRST);

endmodule

`default_nettype wire

//--- source/ahb_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module ahb_apb_bridge (
	input  wire logic             Hclk,
	input  wire logic             Hresetn,
	input  wire ahb_pkg::htrans_e htrans,
	input  wire ahb_pkg::hsize_t  hsize,
	input  wire logic             hwrite,
	input  wire logic             hreadyin,
	input  wire logic             hreadyout_in,
	input  wire ahb_pkg::addr_t   haddr,
	input  wire ahb_pkg::data_t   hwdata,
	output ahb_pkg::hresp_e       hresp,
	output logic                  hreadyout,
	output logic                  valid,
	output regmap_pkg::slave_sel_t pselx_out,
	output ahb_pkg::data_t        config_reg_data
);

	ahb_pkg::addr_t base_0;
	ahb_pkg::addr_t base_1;
	ahb_pkg::addr_t base_2;
	ahb_pkg::addr_t base_3;
	ahb_pkg::addr_t offset_0;
	ahb_pkg::addr_t offset_1;
	ahb_pkg::addr_t offset_2;
	ahb_pkg::addr_t offset_3;
	logic           err_first;
	logic           active;
	logic           cfg_write;

	assign active = hreadyin && (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ);
	assign cfg_write = hwrite && (haddr <= `CFG_ADDR_LAST);

	// config writes stay on the AHB side
	assign valid = active && (hresp == ahb_pkg::OKAY) && !cfg_write;

	always_comb
	begin
		if (hresp == ahb_pkg::ERROR)
			hreadyout = !err_first; // low then high across the error
		else if (cfg_write)
			hreadyout = 1'b1;
		else
			hreadyout = hreadyout_in;
	end

	cfg_regs u_cfg_regs (
		.Hclk            (Hclk),
		.Hresetn         (Hresetn),
		.htrans          (htrans),
		.hwrite          (hwrite),
		.hreadyin        (hreadyin),
		.haddr           (haddr),
		.hwdata          (hwdata),
		.hresp           (hresp),
		.base_0          (base_0),
		.base_1          (base_1),
		.base_2          (base_2),
		.base_3          (base_3),
		.offset_0        (offset_0),
		.offset_1        (offset_1),
		.offset_2        (offset_2),
		.offset_3        (offset_3),
		.config_reg_data (config_reg_data)
	);

	slave_decoder u_slave_decoder (
		.haddr     (haddr),
		.base_0    (base_0),
		.base_1    (base_1),
		.base_2    (base_2),
		.base_3    (base_3),
		.offset_0  (offset_0),
		.offset_1  (offset_1),
		.offset_2  (offset_2),
		.offset_3  (offset_3),
		.pselx_out (pselx_out)
	);

	xfer_checker u_xfer_checker (
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.htrans    (htrans),
		.hsize     (hsize),
		.hwrite    (hwrite),
		.hreadyin  (hreadyin),
		.haddr     (haddr),
		.hresp     (hresp),
		.err_first (err_first)
	);

endmodule

`default_nettype wire

//--- sim/tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "bridge_params.svh"

module tb_bridge;

	logic                   Hclk;
	logic                   Hresetn;
	ahb_pkg::htrans_e       htrans;
	ahb_pkg::hsize_t        hsize;
	logic                   hwrite;
	logic                   hreadyin;
	logic                   hreadyout_in;
	ahb_pkg::addr_t         haddr;
	ahb_pkg::data_t         hwdata;
	ahb_pkg::hresp_e        hresp;
	logic                   hreadyout;
	logic                   valid;
	regmap_pkg::slave_sel_t pselx_out;
	ahb_pkg::data_t         config_reg_data;

	ahb_pkg::addr_t exp_base [`BRIDGE_SLAVES]; // windows as the tests expect them
	ahb_pkg::addr_t exp_off [`BRIDGE_SLAVES];
	logic [31:0]    lcg_state;

	ahb_apb_bridge u_ahb_apb_bridge (
		.Hclk            (Hclk),
		.Hresetn         (Hresetn),
		.htrans          (htrans),
		.hsize           (hsize),
		.hwrite          (hwrite),
		.hreadyin        (hreadyin),
		.hreadyout_in    (hreadyout_in),
		.haddr           (haddr),
		.hwdata          (hwdata),
		.hresp           (hresp),
		.hreadyout       (hreadyout),
		.valid           (valid),
		.pselx_out       (pselx_out),
		.config_reg_data (config_reg_data)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #20 Hclk = ~Hclk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input ahb_pkg::data_t got, input ahb_pkg::data_t exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_sel(input regmap_pkg::slave_sel_t got,
		input regmap_pkg::slave_sel_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_resp(input ahb_pkg::hresp_e got, input ahb_pkg::hresp_e exp,
		input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: %s, got %s expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp));
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// lower bound inclusive and upper exclusive
	function automatic regmap_pkg::slave_sel_t expected_sel(input ahb_pkg::addr_t a);
		regmap_pkg::slave_sel_t s;
		s = '0;
		for (int i = 0; i < `BRIDGE_SLAVES; i++)
			s[i] = (a >= exp_base[i]) && (a < exp_base[i] + exp_off[i]);
		return s;
	endfunction

	function automatic ahb_pkg::data_t expected_cfg(input int k);
		ahb_pkg::data_t v;
		case (k)
			1: v = exp_base[0];
			2: v = exp_off[0];
			3: v = exp_base[1];
			4: v = exp_off[1];
			5: v = exp_base[2];
			6: v = exp_off[2];
			7: v = exp_base[3];
			8: v = exp_off[3];
			default: v = '0; // address 0 reads as zero
		endcase
		return v;
	endfunction

	task automatic drive_bus(input ahb_pkg::htrans_e t, input ahb_pkg::hsize_t s,
		input logic w, input ahb_pkg::addr_t a, input ahb_pkg::data_t d,
		input logic rdy, input logic apb_rdy);
		@(negedge Hclk);
		htrans       = t;
		hsize        = s;
		hwrite       = w;
		haddr        = a;
		hwdata       = d;
		hreadyin     = rdy;
		hreadyout_in = apb_rdy;
		#5; // combinational outputs settle well before the rising edge
	endtask

	task automatic drive_xfer(input ahb_pkg::htrans_e t, input ahb_pkg::hsize_t s,
		input logic w, input ahb_pkg::addr_t a);
		drive_bus(t, s, w, a, '0, 1'b1, 1'b1);
	endtask

	// aligned word read that never faults
	task automatic drive_filler();
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, 32'h8000_0010);
	endtask

	task automatic cfg_read(input ahb_pkg::addr_t a, output ahb_pkg::data_t d);
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, a);
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h0);
		d = config_reg_data;
	endtask

	task automatic cfg_write(input ahb_pkg::addr_t a, input ahb_pkg::data_t v);
		drive_bus(ahb_pkg::NONSEQ, 3'd2, 1'b1, a, '0, 1'b1, 1'b0); // APB side not ready
		check_bit(valid, 1'b0, "valid during config write");
		check_bit(hreadyout, 1'b1, "hreadyout during config write");
		drive_bus(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h0, v, 1'b1, 1'b1); // data phase
	endtask

	task automatic expect_error(input string what);
		check_resp(hresp, ahb_pkg::OKAY, {what, ": response in the faulty address phase"});
		drive_filler(); // ERROR starts at the edge ending that address phase
		check_resp(hresp, ahb_pkg::ERROR, {what, ": first ERROR cycle"});
		check_bit(hreadyout, 1'b0, {what, ": hreadyout in first ERROR cycle"});
		check_bit(valid, 1'b0, {what, ": valid in first ERROR cycle"});
		drive_filler();
		check_resp(hresp, ahb_pkg::ERROR, {what, ": second ERROR cycle"});
		check_bit(hreadyout, 1'b1, {what, ": hreadyout in second ERROR cycle"});
		check_bit(valid, 1'b0, {what, ": valid in second ERROR cycle"});
		drive_filler();
		check_resp(hresp, ahb_pkg::OKAY, {what, ": response after ERROR"});
		check_bit(valid, 1'b1, {what, ": valid after ERROR"});
		drive_filler();
		check_resp(hresp, ahb_pkg::OKAY, {what, ": next transfer"});
	endtask

	task automatic expect_no_error(input string what);
		repeat (3)
		begin
			drive_filler();
			check_resp(hresp, ahb_pkg::OKAY, what);
		end
	endtask

	task automatic reset_state();
		ahb_pkg::data_t d;
		check_resp(hresp, ahb_pkg::OKAY, "hresp after reset");
		check_data(config_reg_data, '0, "config_reg_data after reset");
		for (int i = 0; i < `BRIDGE_SLAVES; i++)
		begin
			drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, exp_base[i]);
			check_sel(pselx_out, regmap_pkg::slave_sel_t'(1 << i), "window base");
			drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, exp_base[i] + exp_off[i] - 1);
			check_sel(pselx_out, regmap_pkg::slave_sel_t'(1 << i), "window top");
			drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, exp_base[i] - 1);
			check_sel(pselx_out, '0, "just below window");
			drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, exp_base[i] + exp_off[i]);
			check_sel(pselx_out, '0, "window limit");
		end
		for (int k = 0; k <= `CFG_ADDR_LAST; k++)
		begin
			cfg_read(ahb_pkg::addr_t'(k), d);
			check_data(d, expected_cfg(k), $sformatf("reset read of config %0d", k));
		end
	endtask

	task automatic config_write_readback();
		ahb_pkg::data_t d;
		cfg_write(32'd5, 32'h9000_0000);
		exp_base[2] = 32'h9000_0000;
		cfg_write(32'd6, 32'h0000_1000);
		exp_off[2] = 32'h0000_1000;
		cfg_read(32'd5, d);
		check_data(d, expected_cfg(5), "read back base 2");
		cfg_read(32'd6, d);
		check_data(d, expected_cfg(6), "read back offset 2");
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h9000_0000);
		check_sel(pselx_out, 4'b0100, "new base of slave 2");
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h9000_0FFF);
		check_sel(pselx_out, 4'b0100, "new top of slave 2");
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h9000_1000);
		check_sel(pselx_out, 4'b0000, "new limit of slave 2");
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h8800_0000);
		check_sel(pselx_out, 4'b0000, "old base of slave 2");
	endtask

	task automatic sequence_faults();
		drive_xfer(ahb_pkg::IDLE, 3'd2, 1'b0, 32'h8000_0020);
		drive_xfer(ahb_pkg::SEQ, 3'd2, 1'b0, 32'h8000_0024);
		expect_error("SEQ after IDLE");
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, 32'h8000_0040);
		drive_xfer(ahb_pkg::SEQ, 3'd1, 1'b0, 32'h8000_0044);
		expect_error("SEQ with changed hsize");
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, 32'h8000_0080);
		drive_xfer(ahb_pkg::SEQ, 3'd2, 1'b0, 32'h8000_0084);
		expect_no_error("matching NONSEQ/SEQ pair");
	endtask

	task automatic pass_through();
		logic [31:0]      r;
		ahb_pkg::addr_t   a;
		ahb_pkg::htrans_e t;
		logic             exp_valid;
		for (int lvl = 0; lvl < 2; lvl++)
		begin
			for (int n = 0; n < 16; n++)
			begin
				r = lcg_next();
				a = {r[31:2], 2'b00};
				if (n[0]) // every other one lands inside a window
					a = exp_base[r[5:4]] + (((r >> 8) % exp_off[r[5:4]]) & ~32'h3);
				if (a <= `CFG_ADDR_LAST)
					a = a | 32'h100;
				case (r[3:2])
					2'd0: t = ahb_pkg::IDLE;
					2'd1: t = ahb_pkg::BUSY;
					default: t = ahb_pkg::NONSEQ;
				endcase
				exp_valid = r[0] && (t == ahb_pkg::NONSEQ);
				drive_bus(t, 3'd2, r[1], a, r, r[0], lvl[0]);
				check_resp(hresp, ahb_pkg::OKAY, "pass-through response");
				check_bit(valid, exp_valid, $sformatf("valid for address %h", a));
				check_bit(hreadyout, lvl[0], "hreadyout follows hreadyout_in");
				check_sel(pselx_out, expected_sel(a), $sformatf("select for address %h", a));
			end
		end
	endtask

	initial
	begin
		#200_000;
		abort_run("simulation ran past its time limit");
	end

	initial
	begin
		lcg_state    = 32'he627_0eb0;
		exp_base[0]  = `SLAVE_BASE_0;
		exp_base[1]  = `SLAVE_BASE_1;
		exp_base[2]  = `SLAVE_BASE_2;
		exp_base[3]  = `SLAVE_BASE_3;
		for (int i = 0; i < `BRIDGE_SLAVES; i++)
			exp_off[i] = `SLAVE_OFFSET_RST;
		Hresetn      = 1'b0;
		htrans       = ahb_pkg::IDLE;
		hsize        = 3'd2;
		hwrite       = 1'b0;
		hreadyin     = 1'b1;
		hreadyout_in = 1'b1;
		haddr        = '0;
		hwdata       = '0;
		repeat (5) @(negedge Hclk);
		Hresetn = 1'b1;

		reset_state();
		config_write_readback();
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, 32'h8000_0002); // word at ...2
		expect_error("misaligned word transfer");
		sequence_faults();
		drive_xfer(ahb_pkg::NONSEQ, 3'd3, 1'b0, 32'h8000_0100);
		expect_error("hsize 3 on a 32-bit bus");
		drive_xfer(ahb_pkg::NONSEQ, 3'd2, 1'b0, 32'h8000_0100);
		expect_no_error("hsize 2 word transfer");
		pass_through();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/ahb_pkg.sv
source/regmap_pkg.sv
source/cfg_regs.sv
source/slave_decoder.sv
source/xfer_checker.sv
source/ahb_apb_bridge.sv
sim/tb_bridge.sv

//--- Makefile
# Verilator build and run of the AHB side of the bridge
# the run's exit status gives pass or fail

VERILATOR ?= verilator
TOP       ?= tb_bridge
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
